// File: design/rv_pkg.sv
package rv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// word and field types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word_t;        // data or address word
	typedef logic [4:0]  reg_addr_t;    // register file index
	typedef logic [31:0] instruction_t; // raw instruction with fields sliced by bit position

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;

	// only addi is decoded among the op-imm group
	localparam logic [2:0] FUNCT3_OP_IMM_ADDI = 3'b000;

	localparam logic [2:0] FUNCT3_OP_ADD_SUB = 3'b000; // funct7 bit 5 picks sub
	localparam logic [2:0] FUNCT3_OP_SLL     = 3'b001;
	localparam logic [2:0] FUNCT3_OP_SLT     = 3'b010;
	localparam logic [2:0] FUNCT3_OP_SLTU    = 3'b011;
	localparam logic [2:0] FUNCT3_OP_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OP_SR      = 3'b101; // funct7 bit 5 picks arithmetic
	localparam logic [2:0] FUNCT3_OP_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_OP_AND     = 3'b111;

	localparam word_t RESET_PC = 32'h0000_0000;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control enums
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND,
		ALU_OP_IN2_PASSTHROUGH
	} alu_op_t;

	typedef enum logic [1:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IR_ITYPE_IMM,
		ALU_IN2_SEL_IR_UTYPE_IMM
	} alu_in2_sel_t;

	// each instruction spends one cycle in FETCH and one in DEMW
	typedef enum logic [1:0] {
		RESET,
		FETCH,
		DEMW
	} ctrl_state_t;

endpackage

// File: design/rv_regfile.sv
module rv_regfile (
	input  logic              clk_i,
	input  logic              reset_i,
	input  rv_pkg::reg_addr_t rs1_i,
	input  rv_pkg::reg_addr_t rs2_i,
	input  rv_pkg::reg_addr_t rd_i,
	input  logic              we_i,
	input  rv_pkg::word_t     wdata_i,
	output rv_pkg::word_t     rdata1_o,
	output rv_pkg::word_t     rdata2_o
);
	import rv_pkg::*;

	// x0 has no storage behind it
	word_t regs [31:1];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (rd_i != '0)) begin
			regs[rd_i] <= wdata_i; // writes to x0 are dropped here
		end
	end

	always_comb begin
		if (rs1_i == '0) begin
			rdata1_o = '0;
		end else begin
			rdata1_o = regs[rs1_i];
		end

		if (rs2_i == '0) begin
			rdata2_o = '0;
		end else begin
			rdata2_o = regs[rs2_i];
		end
	end

endmodule

// File: design/rv_alu.sv
module rv_alu (
	input  rv_pkg::alu_op_t op_i,
	input  rv_pkg::word_t   in1_i,
	input  rv_pkg::word_t   in2_i,
	output rv_pkg::word_t   out_o
);
	import rv_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = in2_i[4:0]; // only the low five bits count for shifts
	assign lt_signed   = $signed(in1_i) < $signed(in2_i);
	assign lt_unsigned = in1_i < in2_i;

	always_comb begin
		case (op_i)
			ALU_OP_ADD:  out_o = in1_i + in2_i;
			ALU_OP_SUB:  out_o = in1_i - in2_i;
			ALU_OP_SLL:  out_o = in1_i << shamt;
			ALU_OP_SLT:  out_o = word_t'(lt_signed);
			ALU_OP_SLTU: out_o = word_t'(lt_unsigned);
			ALU_OP_XOR:  out_o = in1_i ^ in2_i;
			ALU_OP_SRL:  out_o = in1_i >> shamt;
			ALU_OP_SRA:  out_o = word_t'($signed(in1_i) >>> shamt);
			ALU_OP_OR:   out_o = in1_i | in2_i;
			ALU_OP_AND:  out_o = in1_i & in2_i;

			// lui hands its immediate straight through
			ALU_OP_IN2_PASSTHROUGH: out_o = in2_i;
			default:                out_o = '0;
		endcase
	end

endmodule

// File: design/rv_control.sv
module rv_control (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  rv_pkg::instruction_t ir_i,
	output logic                 pc_we_o,
	output logic                 ir_we_o,
	output logic                 regfile_we_o,
	output rv_pkg::alu_op_t      alu_op_o,
	output rv_pkg::alu_in2_sel_t alu_in2_sel_o
);
	import rv_pkg::*;

	ctrl_state_t state;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_b5;

	assign opcode    = ir_i[6:0];
	assign funct3    = ir_i[14:12];
	assign funct7_b5 = ir_i[30]; // selects sub and sra

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= RESET;
		end else begin
			case (state)
				FETCH:   state <= DEMW;
				default: state <= FETCH; // RESET and DEMW both go on to fetch
			endcase
		end
	end

	// the write enables follow the state alone
	always_comb begin
		pc_we_o = 1'b0;
		ir_we_o = 1'b0;
		case (state)
			FETCH:   ir_we_o = 1'b1;
			DEMW:    pc_we_o = 1'b1;
			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		regfile_we_o  = 1'b0; // unknown encodings retire without a write
		alu_op_o      = ALU_OP_ADD;
		alu_in2_sel_o = ALU_IN2_SEL_REGFILE_OUT2;

		if (state == DEMW) begin
			case (opcode)
				OPCODE_LUI: begin
					regfile_we_o  = 1'b1;
					alu_op_o      = ALU_OP_IN2_PASSTHROUGH;
					alu_in2_sel_o = ALU_IN2_SEL_IR_UTYPE_IMM;
				end
				OPCODE_OP_IMM: begin
					if (funct3 == FUNCT3_OP_IMM_ADDI) begin
						regfile_we_o  = 1'b1;
						alu_op_o      = ALU_OP_ADD;
						alu_in2_sel_o = ALU_IN2_SEL_IR_ITYPE_IMM;
					end
				end
				OPCODE_OP: begin
					regfile_we_o  = 1'b1; // all eight funct3 values are defined here
					alu_in2_sel_o = ALU_IN2_SEL_REGFILE_OUT2;
					case (funct3)
						FUNCT3_OP_ADD_SUB: alu_op_o = funct7_b5 ? ALU_OP_SUB : ALU_OP_ADD;
						FUNCT3_OP_SLL:     alu_op_o = ALU_OP_SLL;
						FUNCT3_OP_SLT:     alu_op_o = ALU_OP_SLT;
						FUNCT3_OP_SLTU:    alu_op_o = ALU_OP_SLTU;
						FUNCT3_OP_XOR:     alu_op_o = ALU_OP_XOR;
						FUNCT3_OP_SR:      alu_op_o = funct7_b5 ? ALU_OP_SRA : ALU_OP_SRL;
						FUNCT3_OP_OR:      alu_op_o = ALU_OP_OR;
						FUNCT3_OP_AND:     alu_op_o = ALU_OP_AND;
						default:           alu_op_o = ALU_OP_ADD;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// File: design/rv_datapath.sv
module rv_datapath (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 pc_we_i,
	input  logic                 ir_we_i,
	input  logic                 regfile_we_i,
	input  rv_pkg::alu_op_t      alu_op_i,
	input  rv_pkg::alu_in2_sel_t alu_in2_sel_i,
	input  rv_pkg::word_t        mem_rdata_i,
	output rv_pkg::instruction_t ir_o,
	output rv_pkg::word_t        mem_addr_o,
	output rv_pkg::word_t        wb_data_o,
	output rv_pkg::reg_addr_t    wb_rd_o
);
	import rv_pkg::*;

	word_t        pc;
	instruction_t ir;

	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;

	word_t imm_i;
	word_t imm_u;
	word_t rf_rdata1;
	word_t rf_rdata2;
	word_t alu_in2;
	word_t alu_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program counter and instruction register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc <= RESET_PC;
		end else if (pc_we_i) begin
			pc <= pc + word_t'(4);
		end
	end

	always_ff @(posedge clk_i) begin
		if (ir_we_i) begin
			ir <= mem_rdata_i;
		end
	end

	assign mem_addr_o = pc; // memory is only ever read for instructions
	assign ir_o       = ir;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand fields and immediates
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign rs1 = ir[19:15];
	assign rs2 = ir[24:20];
	assign rd  = ir[11:7];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_u = {ir[31:12], 12'b0};

	always_comb begin
		case (alu_in2_sel_i)
			ALU_IN2_SEL_IR_ITYPE_IMM: alu_in2 = imm_i;
			ALU_IN2_SEL_IR_UTYPE_IMM: alu_in2 = imm_u;
			default:                  alu_in2 = rf_rdata2;
		endcase
	end

	rv_regfile i_regfile (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.rd_i     (rd),
		.we_i     (regfile_we_i),
		.wdata_i  (alu_out),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2)
	);

	// the first operand is always rs1
	rv_alu i_alu (
		.op_i  (alu_op_i),
		.in1_i (rf_rdata1),
		.in2_i (alu_in2),
		.out_o (alu_out)
	);

	assign wb_data_o = alu_out;
	assign wb_rd_o   = rd;

endmodule

// File: design/rv_core.sv
module rv_core (
	input  logic              clk_i,
	input  logic              reset_i,
	input  rv_pkg::word_t     mem_rdata_i,
	output rv_pkg::word_t     mem_addr_o,
	output logic              wb_we_o,
	output rv_pkg::reg_addr_t wb_rd_o,
	output rv_pkg::word_t     wb_data_o
);
	import rv_pkg::*;

	logic         pc_we;
	logic         ir_we;
	logic         regfile_we;
	alu_op_t      alu_op;
	alu_in2_sel_t alu_in2_sel;
	instruction_t ir;

	rv_control i_control (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.ir_i          (ir),
		.pc_we_o       (pc_we),
		.ir_we_o       (ir_we),
		.regfile_we_o  (regfile_we),
		.alu_op_o      (alu_op),
		.alu_in2_sel_o (alu_in2_sel)
	);

	rv_datapath i_datapath (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.pc_we_i       (pc_we),
		.ir_we_i       (ir_we),
		.regfile_we_i  (regfile_we),
		.alu_op_i      (alu_op),
		.alu_in2_sel_i (alu_in2_sel),
		.mem_rdata_i   (mem_rdata_i),
		.ir_o          (ir),
		.mem_addr_o    (mem_addr_o),
		.wb_data_o     (wb_data_o),
		.wb_rd_o       (wb_rd_o)
	);

	// trace shows the raw enable, so x0 writes are visible here
	assign wb_we_o = regfile_we;

endmodule

// File: sim/rv_core_tb.sv
module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rv_pkg::*;

	localparam int          PROG_LEN       = 400;
	localparam int          TIMEOUT_CYCLES = 2 * PROG_LEN + 200; // two cycles per instruction
	localparam logic [31:0] SEED           = 32'h6c1a;
	localparam time         DRIVE_DELAY    = 1ns;

	logic      clk_i   = 1'b0;
	logic      reset_i = 1'b1;
	word_t     mem_rdata_i;
	word_t     mem_addr_o;
	logic      wb_we_o;
	reg_addr_t wb_rd_o;
	word_t     wb_data_o;

	instruction_t imem [PROG_LEN];
	word_t        model_regs [32];
	int           cycle_count = 0;

	rv_core i_dut (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.mem_rdata_i (mem_rdata_i),
		.mem_addr_o  (mem_addr_o),
		.wb_we_o     (wb_we_o),
		.wb_rd_o     (wb_rd_o),
		.wb_data_o   (wb_data_o)
	);

	always #5 clk_i = ~clk_i;

	// instruction memory answers in the same cycle and maps nothing past the program
	always_comb begin
		if (mem_addr_o[31:2] < PROG_LEN) begin
			mem_rdata_i = imem[mem_addr_o[31:2]];
		end else begin
			mem_rdata_i = 'x;
		end
	end

	always @(posedge clk_i) begin
		cycle_count++;
		assert (cycle_count < TIMEOUT_CYCLES) else begin
			$display("timeout, the core made no progress within %0d cycles", cycle_count);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input word_t got, input word_t expected);
		$display("FAILED %s: got %h, expected %h", name, got, expected);
		abort_run();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program generator and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic instruction_t random_instruction();
		instruction_t instr;
		int unsigned  kind;
		logic [6:0]   opcode;
		instr = $urandom; // register indices and immediates stay random
		kind  = $urandom_range(99);
		if (kind < 15) begin
			instr[6:0] = OPCODE_LUI;
		end else if (kind < 40) begin
			instr[6:0]   = OPCODE_OP_IMM;
			instr[14:12] = FUNCT3_OP_IMM_ADDI;
		end else if (kind < 90) begin
			instr[6:0]   = OPCODE_OP;
			instr[31:25] = {1'b0, instr[30], 5'b0};
		end else if (kind < 95) begin
			instr[6:0]   = OPCODE_OP_IMM; // op-imm forms other than addi
			instr[14:12] = 3'($urandom_range(7, 1));
		end else begin
			do begin
				opcode = 7'($urandom);
			end while (opcode inside {OPCODE_LUI, OPCODE_OP_IMM, OPCODE_OP});
			instr[6:0] = opcode;
		end
		return instr;
	endfunction

	// returns 1 when the instruction writes back and leaves the value in result
	function automatic logic predict(input instruction_t instr, output word_t result);
		word_t             src1;
		word_t             src2;
		logic signed [31:0] src1_signed;
		logic [4:0]        shamt;
		logic              writes;
		src1        = model_regs[instr[19:15]];
		src2        = model_regs[instr[24:20]];
		src1_signed = src1;
		shamt       = src2[4:0];
		result      = '0;
		writes      = 1'b1;
		case (instr[6:0])
			OPCODE_LUI: result = {instr[31:12], 12'h000};
			OPCODE_OP_IMM: begin
				if (instr[14:12] == FUNCT3_OP_IMM_ADDI) begin
					result = src1 + {{20{instr[31]}}, instr[31:20]};
				end else begin
					writes = 1'b0;
				end
			end
			OPCODE_OP: begin
				case (instr[14:12])
					FUNCT3_OP_ADD_SUB: result = instr[30] ? src1 - src2 : src1 + src2;
					FUNCT3_OP_SLL:     result = src1 << shamt;
					FUNCT3_OP_SLT:     result = ($signed(src1) < $signed(src2)) ? 32'd1 : 32'd0;
					FUNCT3_OP_SLTU:    result = (src1 < src2) ? 32'd1 : 32'd0;
					FUNCT3_OP_XOR:     result = src1 ^ src2;
					FUNCT3_OP_SR: begin
						if (instr[30]) begin
							result = src1_signed >>> shamt; // sign bit fills from the top
						end else begin
							result = src1 >> shamt;
						end
					end
					FUNCT3_OP_OR:      result = src1 | src2;
					default:           result = src1 & src2;
				endcase
			end
			default: writes = 1'b0;
		endcase
		return writes;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		instruction_t instr;
		word_t        exp_data;
		word_t        exp_addr;
		logic         exp_we;
		void'($urandom(SEED));
		for (int i = 0; i < PROG_LEN; i++) begin
			imem[i] = random_instruction();
		end
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end

		repeat (3) @(posedge clk_i);
		#DRIVE_DELAY reset_i = 1'b0;

		// the first cycle out of reset comes before the first fetch
		@(negedge clk_i);
		assert (mem_addr_o == RESET_PC) else report_mismatch("mem_addr_o", mem_addr_o, RESET_PC);
		assert (wb_we_o == 1'b0) else report_mismatch("wb_we_o", wb_we_o, 0);

		for (int n = 0; n < PROG_LEN; n++) begin
			instr    = imem[n];
			exp_addr = RESET_PC + 32'(4 * n);
			exp_we   = predict(instr, exp_data);

			@(negedge clk_i); // fetch cycle
			assert (mem_addr_o == exp_addr) else report_mismatch("mem_addr_o", mem_addr_o, exp_addr);
			assert (wb_we_o == 1'b0) else report_mismatch("wb_we_o", wb_we_o, 0);

			@(negedge clk_i); // execute cycle
			assert (mem_addr_o == exp_addr) else report_mismatch("mem_addr_o", mem_addr_o, exp_addr);
			assert (wb_we_o == exp_we) else report_mismatch("wb_we_o", wb_we_o, 32'(exp_we));
			if (exp_we) begin
				assert (wb_rd_o == instr[11:7]) else report_mismatch("wb_rd_o", wb_rd_o, instr[11:7]);
				assert (wb_data_o == exp_data) else report_mismatch("wb_data_o", wb_data_o, exp_data);
				if (instr[11:7] != 5'd0) begin
					model_regs[instr[11:7]] = exp_data; // x0 keeps reading zero
				end
			end
		end

		$display("No errors");
		$finish;
	end

endmodule

// File: rv_core.f
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_control.sv
design/rv_datapath.sv
design/rv_core.sv
sim/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/rv_regfile.sv
  - design/rv_alu.sv
  - design/rv_control.sv
  - design/rv_datapath.sv
  - design/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_tb.sv
